/* floating_alu.f */
common/fpu_pkg.sv
common/fpu_stage_if.sv
fp_arith/fp_align.sv
fp_arith/fp_mantissa_op.sv
fp_arith/fp_normalize.sv
fp_arith/fp_round_pack.sv
hdl/floating_alu.sv
tests/tb_floating_alu.sv

/* Makefile */
TOP := tb_floating_alu

.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ps --top-module $(TOP) \
		-f floating_alu.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log

/* tests/tb_floating_alu.sv */
module tb_floating_alu;
    timeunit 1ns;
    timeprecision 1ps;
    import fpu_pkg::*;

    localparam int TIMEOUT_CYCLES = 2000;
    localparam int DRAIN_CYCLES   = 8;

    logic     clk;
    logic     rst;
    fp_word_t op1;
    fp_word_t op2;
    alu_op_t  instruction;
    fp_word_t result;
    logic     valid;

    int          cycle = 0;
    int          drain;
    logic [31:0] lcg_state = 32'd1212;
    int          due_q[$];
    fp_word_t    expect_q[$];

    floating_alu uut (
        .clk         (clk),
        .rst         (rst),
        .op1         (op1),
        .op2         (op2),
        .instruction (instruction),
        .result      (result),
        .valid       (valid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("Error: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    end

    // ============================================================
    // Checking
    // ============================================================
    task automatic check_value(string name, logic [31:0] actual, logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    endtask

    // Results are taken at the falling edge of their due cycle
    always @(negedge clk) begin
        if (due_q.size() != 0 && due_q[0] == cycle) begin
            check_value("valid", 32'(valid), 32'd1);
            check_value("result", result, expect_q[0]);
            void'(due_q.pop_front());
            void'(expect_q.pop_front());
        end
    end

    // ============================================================
    // Reference model and random source
    // ============================================================
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Normal word with an exponent between 64 and 190
    function automatic fp_word_t random_normal();
        logic [31:0] r;
        logic [31:0] f;
        int          e;
        r = next_rand();
        f = next_rand();
        e = 64 + int'(r[30:23]) % 127;
        return {r[31], 8'(e), f[31:9]};
    endfunction

    // Rounds m * 2^(e-150) to nearest even and packs it
    function automatic fp_word_t pack_ref(logic sign, int e, logic [63:0] m);
        int          p;
        int          sh;
        logic [63:0] keep;
        logic [63:0] low;
        logic        guard;
        logic        rest;
        p     = 0;
        guard = 1'b0;
        rest  = 1'b0;
        if (m == 64'd0) begin
            return 32'd0;
        end
        for (int i = 0; i < 64; i++) begin
            if ((m >> i) != 64'd0) begin
                p = i;
            end
        end
        if (p > 23) begin
            sh    = p - 23;
            keep  = m >> sh;
            low   = m >> (sh - 1);
            guard = low[0];
            rest  = (m & ((64'd1 << (sh - 1)) - 64'd1)) != 64'd0;
            e     = e + sh;
        end else begin
            keep = m << (23 - p);
            e    = e - (23 - p);
        end
        if (guard && (rest || keep[0])) begin
            keep = keep + 64'd1;
        end
        if (keep[24]) begin
            keep = keep >> 1;
            e    = e + 1;
        end
        if (e >= 255) begin
            return {sign, 8'hFF, 23'd0};
        end
        if (e <= 0) begin
            return {sign, 31'd0};
        end
        return {sign, 8'(e), keep[22:0]};
    endfunction

    // Exact sum on a common scale and one final rounding
    function automatic fp_word_t add_ref(fp_word_t a, fp_word_t b, logic negate_b);
        logic        sa;
        logic        sb;
        logic        s;
        int          ea;
        int          eb;
        int          emin;
        logic [63:0] ma;
        logic [63:0] mb;
        logic [63:0] m;
        sa   = a[31];
        sb   = b[31] ^ negate_b;
        ea   = int'(a[30:23]);
        eb   = int'(b[30:23]);
        emin = (ea < eb) ? ea : eb;
        ma   = {40'd0, 1'b1, a[22:0]} << (ea - emin);
        mb   = {40'd0, 1'b1, b[22:0]} << (eb - emin);
        if (sa == sb) begin
            m = ma + mb;
            s = sa;
        end else if (ma >= mb) begin
            m = ma - mb;
            s = sa;
        end else begin
            m = mb - ma;
            s = sb;
        end
        return pack_ref(s, emin, m);
    endfunction

    function automatic fp_word_t mul_ref(fp_word_t a, fp_word_t b);
        logic [63:0] m;
        m = {40'd0, 1'b1, a[22:0]} * {40'd0, 1'b1, b[22:0]};
        return pack_ref(a[31] ^ b[31], int'(a[30:23]) + int'(b[30:23]) - 150, m);
    endfunction

    // Signed ordering key where both zeros map to 0
    function automatic longint order_key(fp_word_t w);
        longint mag;
        mag = longint'(w[30:0]);
        return w[31] ? -mag : mag;
    endfunction

    function automatic fp_word_t expected_word(alu_op_t op, fp_word_t a, fp_word_t b);
        case (op)
            FADD:    return add_ref(a, b, 1'b0);
            FSUB:    return add_ref(a, b, 1'b1);
            FMUL:    return mul_ref(a, b);
            FNEG:    return {~a[31], a[30:0]};
            FABS:    return {1'b0, a[30:0]};
            FEQ:     return (order_key(a) == order_key(b)) ? 32'd1 : 32'd0;
            FSLT:    return (order_key(a) < order_key(b)) ? 32'd1 : 32'd0;
            default: return 32'd0;
        endcase
    endfunction

    // ============================================================
    // Stimulus
    // ============================================================
    // Sampled at the next edge and due three edges after that
    task automatic drive_op(alu_op_t op, fp_word_t a, fp_word_t b);
        instruction <= op;
        op1         <= a;
        op2         <= b;
        due_q.push_back(cycle + 5);
        expect_q.push_back(expected_word(op, a, b));
    endtask

    task automatic issue_op(alu_op_t op, fp_word_t a, fp_word_t b);
        @(posedge clk);
        drive_op(op, a, b);
    endtask

    task automatic reset_and_latency();
        @(posedge clk);
        repeat (3) begin
            @(negedge clk);
            check_value("valid", 32'(valid), 32'd0);
            check_value("result", result, 32'd0);
            @(posedge clk);
        end
        rst <= 1'b0;
        drive_op(FADD, 32'h3FC0_0000, 32'h4010_0000);
        repeat (4) begin
            @(negedge clk);
            check_value("valid", 32'(valid), 32'd0);
        end
    endtask

    task automatic add_sub_tests();
        issue_op(FADD, 32'h3FC0_0000, 32'h3FE0_0000);
        issue_op(FSUB, 32'h4040_0000, 32'h4020_0000);
        issue_op(FADD, 32'h3F80_0000, 32'hBF40_0000);
        issue_op(FADD, 32'hC000_0000, 32'h40A0_0000);
        issue_op(FSUB, 32'h3F80_0000, 32'hBF80_0000);
        // One-LSB difference needs a 23-place left shift
        issue_op(FSUB, 32'h3F80_0000, 32'h3F80_0001);
        issue_op(FSUB, 32'h40B0_0000, 32'h40B0_0000);
        issue_op(FADD, 32'hC040_0000, 32'h4040_0000);
        issue_op(FADD, 32'h42C8_0000, 32'h3F80_0000);
    endtask

    task automatic mul_tests();
        // Significand product 2^47 - 1 rounds up and carries into the exponent
        issue_op(FMUL, 32'h3FCA_6691, 32'h3FA1_E58F);
        issue_op(FMUL, 32'h6400_0000, 32'hE400_0000);
        repeat (16) begin
            issue_op(FMUL, random_normal(), random_normal());
        end
    endtask

    task automatic sign_op_tests();
        fp_word_t w;
        issue_op(FNEG, 32'h0000_0000, 32'h0000_0000);
        issue_op(FNEG, 32'h8000_0000, 32'h0000_0000);
        issue_op(FABS, 32'h8000_0000, 32'h0000_0000);
        issue_op(FABS, 32'hC049_0FDB, 32'h0000_0000);
        repeat (6) begin
            w = next_rand();
            issue_op(FNEG, w, 32'h0000_0000);
            issue_op(FABS, w | 32'h8000_0000, 32'h0000_0000);
        end
    endtask

    task automatic compare_tests();
        issue_op(FEQ, 32'h3F80_0000, 32'h3F80_0000);
        issue_op(FEQ, 32'h3F80_0000, 32'hBF80_0000);
        issue_op(FEQ, 32'h0000_0000, 32'h8000_0000);
        issue_op(FSLT, 32'h0000_0000, 32'h8000_0000);
        issue_op(FSLT, 32'h8000_0000, 32'h0000_0000);
        issue_op(FSLT, 32'hBF80_0000, 32'h3F80_0000);
        issue_op(FSLT, 32'h3F80_0000, 32'hBF80_0000);
        issue_op(FSLT, 32'hC000_0000, 32'hBF80_0000);
        issue_op(FSLT, 32'hBF80_0000, 32'hBF80_0000);
        issue_op(FSLT, 32'h3F80_0000, 32'h4000_0000);
    endtask

    // Back-to-back mixed ops where add operands keep alignment exact
    task automatic stream_test();
        alu_op_t     op;
        fp_word_t    a;
        fp_word_t    b;
        logic [31:0] r;
        for (int i = 0; i < 64; i++) begin
            r  = next_rand();
            op = alu_op_t'(3'((r >> 16) % 7));
            if (op == FADD || op == FSUB) begin
                a = random_normal() & 32'hFFFF_FF00;
                b = random_normal() & 32'hFFFF_FF00;
                b[30:23] = 8'(int'(a[30:23]) + int'(r[26:24]) - 4);
            end else if (op == FMUL) begin
                a = random_normal();
                b = random_normal();
            end else begin
                a = next_rand();
                b = r[27] ? (a ^ 32'h8000_0000) : next_rand();
            end
            issue_op(op, a, b);
        end
    endtask

    initial begin
        rst         = 1'b1;
        op1         = '0;
        op2         = '0;
        instruction = FADD;
        reset_and_latency();
        add_sub_tests();
        mul_tests();
        sign_op_tests();
        compare_tests();
        stream_test();

        drain = 0;
        while (due_q.size() != 0 && drain < DRAIN_CYCLES) begin
            @(posedge clk);
            drain++;
        end
        if (due_q.size() != 0) begin
            $display("Error: %0d expected results never came out of the pipeline",
                     due_q.size());
            $display("FAIL: see errors above");
            $fatal(1);
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

/* hdl/floating_alu.sv */
module floating_alu (
    input  logic              clk,
    input  logic              rst,
    input  fpu_pkg::fp_word_t op1,
    input  fpu_pkg::fp_word_t op2,
    input  fpu_pkg::alu_op_t  instruction,
    output fpu_pkg::fp_word_t result,
    output logic              valid
);

    // ============================================================
    // Stage-to-stage buses
    // ============================================================
    align_if align_bus ();
    norm_if  norm_bus ();
    round_if round_bus ();

    // Stage 1, operand capture and exponent alignment
    fp_align u_align (
        .clk         (clk),
        .rst         (rst),
        .op1         (op1),
        .op2         (op2),
        .instruction (instruction),
        .out         (align_bus.source)
    );

    // Stage 2, significand add/subtract or multiply
    fp_mantissa_op u_mantissa_op (
        .clk (clk),
        .rst (rst),
        .in  (align_bus.sink),
        .out (norm_bus.source)
    );

    // Stage 3, leading-one normalization and GRS bits
    fp_normalize u_normalize (
        .clk (clk),
        .rst (rst),
        .in  (norm_bus.sink),
        .out (round_bus.source)
    );

    // Stage 4, rounding, packing and the non-arithmetic ops
    fp_round_pack u_round_pack (
        .clk    (clk),
        .rst    (rst),
        .in     (round_bus.sink),
        .result (result),
        .valid  (valid)
    );

endmodule

/* fp_arith/fp_round_pack.sv */
module fp_round_pack (
    input  logic              clk,
    input  logic              rst,
    round_if.sink             in,
    output fpu_pkg::fp_word_t result,
    output logic              valid
);
    import fpu_pkg::*;

    logic       valid_q;
    alu_op_t    op_q;
    fp_word_t   raw_a_q;
    fp_word_t   raw_b_q;
    logic       sign_q;
    exp_t       exp_q;
    sig_t       sig_q;
    logic       round_up_q;
    sum_t       sig_rnd;
    logic [8:0] exp_wide;
    fp_word_t   arith_word;
    logic       both_zero;
    logic       a_less;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q    <= 1'b0;
            op_q       <= FADD;
            raw_a_q    <= '0;
            raw_b_q    <= '0;
            sign_q     <= 1'b0;
            exp_q      <= '0;
            sig_q      <= '0;
            round_up_q <= 1'b0;
        end else begin
            valid_q    <= in.valid;
            op_q       <= in.op;
            raw_a_q    <= in.raw_a;
            raw_b_q    <= in.raw_b;
            sign_q     <= in.sign;
            exp_q      <= in.exp;
            sig_q      <= in.sig;
            round_up_q <= in.round_up;
        end
    end

    // ============================================================
    // Rounding and packing of arithmetic results
    // ============================================================
    always_comb begin
        sig_rnd  = {1'b0, sig_q} + sum_t'(round_up_q);
        exp_wide = {1'b0, exp_q};
        if (sig_rnd[SIG_W]) begin
            // Rounding carried out of the significand
            sig_rnd  = sig_rnd >> 1;
            exp_wide = exp_wide + 9'd1;
        end

        if (exp_wide >= 9'(EXP_INF)) begin
            arith_word = {sign_q, EXP_INF, {FRAC_W{1'b0}}};
        end else if (exp_wide == '0) begin
            arith_word = {sign_q, 31'd0};
        end else begin
            arith_word = {sign_q, exp_wide[7:0], sig_rnd[FRAC_W-1:0]};
        end
    end

    // ============================================================
    // Sign-magnitude compares on the raw words
    // ============================================================
    assign both_zero = (raw_a_q[30:0] == '0) && (raw_b_q[30:0] == '0);

    always_comb begin
        if (raw_a_q[31] != raw_b_q[31]) begin
            a_less = raw_a_q[31];
        end else if (raw_a_q[31]) begin
            // Both negative, larger magnitude is smaller
            a_less = raw_a_q[30:0] > raw_b_q[30:0];
        end else begin
            a_less = raw_a_q[30:0] < raw_b_q[30:0];
        end
    end

    always_comb begin
        case (op_q)
            FADD, FSUB, FMUL: result = arith_word;
            FNEG:    result = {~raw_a_q[31], raw_a_q[30:0]};
            FABS:    result = {1'b0, raw_a_q[30:0]};
            FEQ:     result = (raw_a_q == raw_b_q || both_zero) ? TRUE_WORD : FALSE_WORD;
            FSLT:    result = (a_less && !both_zero) ? TRUE_WORD : FALSE_WORD;
            default: result = FALSE_WORD;
        endcase
    end

    assign valid = valid_q;

endmodule

/* fp_arith/fp_normalize.sv */
module fp_normalize (
    input  logic    clk,
    input  logic    rst,
    norm_if.sink    in,
    round_if.source out
);
    import fpu_pkg::*;

    logic       valid_q;
    alu_op_t    op_q;
    fp_word_t   raw_a_q;
    fp_word_t   raw_b_q;
    logic       sign_q;
    exp_t       exp_q;
    sum_t       sum_q;
    prod_t      prod_q;
    logic [4:0] lead;
    logic [4:0] shift;
    sig_t       sig;
    logic       guard;
    logic       rnd;
    logic       sticky;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
            op_q    <= FADD;
            raw_a_q <= '0;
            raw_b_q <= '0;
            sign_q  <= 1'b0;
            exp_q   <= '0;
            sum_q   <= '0;
            prod_q  <= '0;
        end else begin
            valid_q <= in.valid;
            op_q    <= in.op;
            raw_a_q <= in.raw_a;
            raw_b_q <= in.raw_b;
            sign_q  <= in.sign;
            exp_q   <= in.exp;
            sum_q   <= in.sum;
            prod_q  <= in.prod;
        end
    end

    // Leading-one search below the carry bit, highest set bit wins
    always_comb begin
        lead = '0;
        for (int i = 0; i < SIG_W; i++) begin
            if (sum_q[i]) begin
                lead = 5'(i);
            end
        end
        shift = 5'(SIG_W - 1) - lead;
    end

    always_comb begin
        out.valid = valid_q;
        out.op    = op_q;
        out.raw_a = raw_a_q;
        out.raw_b = raw_b_q;
        out.sign  = sign_q;
        out.exp   = exp_q;
        sig       = '0;
        guard     = 1'b0;
        rnd       = 1'b0;
        sticky    = 1'b0;

        case (op_q)
            FADD, FSUB: begin
                if (sum_q[SIG_W]) begin
                    // Carry out, the dropped LSB becomes the guard bit
                    sig     = sum_q[SIG_W:1];
                    guard   = sum_q[0];
                    out.exp = exp_q + 8'd1;
                end else if (sum_q == '0 || exp_t'(shift) >= exp_q) begin
                    // Full cancellation or underflow, flush to +0
                    out.sign = 1'b0;
                    out.exp  = '0;
                end else begin
                    sig     = sum_q[SIG_W-1:0] << shift;
                    out.exp = exp_q - exp_t'(shift);
                end
            end
            FMUL: begin
                if (prod_q[47]) begin
                    sig    = prod_q[47:24];
                    guard  = prod_q[23];
                    rnd    = prod_q[22];
                    sticky = |prod_q[21:0];
                    // Saturated exponents stay put
                    if (exp_q != '0 && exp_q != EXP_INF) begin
                        out.exp = exp_q + 8'd1;
                    end
                end else begin
                    sig    = prod_q[46:23];
                    guard  = prod_q[22];
                    rnd    = prod_q[21];
                    sticky = |prod_q[20:0];
                end
            end
            default: ;
        endcase

        out.sig = sig;
        // Round to nearest, ties to even
        out.round_up = guard & (rnd | sticky | sig[0]);
    end

endmodule

/* fp_arith/fp_mantissa_op.sv */
module fp_mantissa_op (
    input  logic    clk,
    input  logic    rst,
    align_if.sink   in,
    norm_if.source  out
);
    import fpu_pkg::*;

    logic       valid_q;
    alu_op_t    op_q;
    fp_word_t   raw_a_q;
    fp_word_t   raw_b_q;
    logic       sign_a_q;
    logic       sign_b_q;
    sig_t       sig_a_q;
    sig_t       sig_b_q;
    exp_t       exp_a_q;
    exp_t       exp_b_q;
    exp_t       exp_diff_q;
    logic       a_larger_q;
    exp_t       big_exp_q;
    sum_t       aligned_a;
    sum_t       aligned_b;
    logic [9:0] exp_sum;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q    <= 1'b0;
            op_q       <= FADD;
            raw_a_q    <= '0;
            raw_b_q    <= '0;
            sign_a_q   <= 1'b0;
            sign_b_q   <= 1'b0;
            sig_a_q    <= '0;
            sig_b_q    <= '0;
            exp_a_q    <= '0;
            exp_b_q    <= '0;
            exp_diff_q <= '0;
            a_larger_q <= 1'b0;
            big_exp_q  <= '0;
        end else begin
            valid_q    <= in.valid;
            op_q       <= in.op;
            raw_a_q    <= in.raw_a;
            raw_b_q    <= in.raw_b;
            sign_a_q   <= in.sign_a;
            sign_b_q   <= in.sign_b;
            sig_a_q    <= in.sig_a;
            sig_b_q    <= in.sig_b;
            exp_a_q    <= in.exp_a;
            exp_b_q    <= in.exp_b;
            exp_diff_q <= in.exp_diff;
            a_larger_q <= in.a_larger;
            big_exp_q  <= in.big_exp;
        end
    end

    // Shift the smaller-exponent significand down to the common exponent
    always_comb begin
        aligned_a = {1'b0, sig_a_q};
        aligned_b = {1'b0, sig_b_q};
        if (a_larger_q) begin
            aligned_b = aligned_b >> exp_diff_q;
        end else begin
            aligned_a = aligned_a >> exp_diff_q;
        end
    end

    // Product exponent before the bias is removed
    assign exp_sum = {2'b00, exp_a_q} + {2'b00, exp_b_q};

    always_comb begin
        out.valid = valid_q;
        out.op    = op_q;
        out.raw_a = raw_a_q;
        out.raw_b = raw_b_q;
        out.sign  = sign_a_q;
        out.exp   = exp_a_q;
        out.sum   = '0;
        out.prod  = '0;

        case (op_q)
            FADD, FSUB: begin
                out.exp = big_exp_q;
                if (sign_a_q == sign_b_q) begin
                    out.sum = aligned_a + aligned_b;
                end else if (aligned_a >= aligned_b) begin
                    out.sum = aligned_a - aligned_b;
                end else begin
                    // b dominates, so the result takes its sign
                    out.sum  = aligned_b - aligned_a;
                    out.sign = sign_b_q;
                end
            end
            FMUL: begin
                out.prod = prod_t'(sig_a_q) * prod_t'(sig_b_q);
                out.sign = sign_a_q ^ sign_b_q;
                // Clamp so later increments cannot wrap the 8-bit field
                if (exp_sum <= 10'(EXP_BIAS)) begin
                    out.exp = '0;
                end else if (exp_sum >= 10'(EXP_BIAS) + 10'(EXP_INF)) begin
                    out.exp = EXP_INF;
                end else begin
                    out.exp = exp_t'(exp_sum - 10'(EXP_BIAS));
                end
            end
            default: ;
        endcase
    end

endmodule

/* fp_arith/fp_align.sv */
module fp_align (
    input  logic              clk,
    input  logic              rst,
    input  fpu_pkg::fp_word_t op1,
    input  fpu_pkg::fp_word_t op2,
    input  fpu_pkg::alu_op_t  instruction,
    align_if.source           out
);
    import fpu_pkg::*;

    fp_word_t op1_q;
    fp_word_t op2_q;
    alu_op_t  op_q;
    logic     valid_q;
    exp_t     exp_a;
    exp_t     exp_b;

    // Input register layer, valid rises on the first edge out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            op1_q   <= '0;
            op2_q   <= '0;
            op_q    <= FADD;
            valid_q <= 1'b0;
        end else begin
            op1_q   <= op1;
            op2_q   <= op2;
            op_q    <= instruction;
            valid_q <= 1'b1;
        end
    end

    assign exp_a = op1_q[FRAC_W +: 8];
    assign exp_b = op2_q[FRAC_W +: 8];

    always_comb begin
        out.valid  = valid_q;
        out.op     = op_q;
        out.raw_a  = op1_q;
        out.raw_b  = op2_q;
        out.sign_a = op1_q[31];
        // Subtraction becomes an add of the negated second operand
        out.sign_b = (op_q == FSUB) ? ~op2_q[31] : op2_q[31];
        out.sig_a  = {1'b1, op1_q[FRAC_W-1:0]};
        out.sig_b  = {1'b1, op2_q[FRAC_W-1:0]};
        out.exp_a  = exp_a;
        out.exp_b  = exp_b;

        // Equal exponents count as a larger
        if (exp_a >= exp_b) begin
            out.a_larger = 1'b1;
            out.exp_diff = exp_a - exp_b;
            out.big_exp  = exp_a;
        end else begin
            out.a_larger = 1'b0;
            out.exp_diff = exp_b - exp_a;
            out.big_exp  = exp_b;
        end
    end

endmodule

/* common/fpu_stage_if.sv */
// Stage 1 to stage 2, unpacked and aligned operands
interface align_if;
    import fpu_pkg::*;

    logic     valid;
    alu_op_t  op;
    fp_word_t raw_a;
    fp_word_t raw_b;
    logic     sign_a;
    // Already inverted for FSUB
    logic     sign_b;
    sig_t     sig_a;
    sig_t     sig_b;
    exp_t     exp_a;
    exp_t     exp_b;
    exp_t     exp_diff;
    logic     a_larger;
    exp_t     big_exp;

    modport source (output valid, op, raw_a, raw_b, sign_a, sign_b, sig_a, sig_b,
                    exp_a, exp_b, exp_diff, a_larger, big_exp);
    modport sink   (input valid, op, raw_a, raw_b, sign_a, sign_b, sig_a, sig_b,
                    exp_a, exp_b, exp_diff, a_larger, big_exp);
endinterface

// Stage 2 to stage 3, raw sum or product before normalization
interface norm_if;
    import fpu_pkg::*;

    logic     valid;
    alu_op_t  op;
    fp_word_t raw_a;
    fp_word_t raw_b;
    logic     sign;
    exp_t     exp;
    sum_t     sum;
    prod_t    prod;

    modport source (output valid, op, raw_a, raw_b, sign, exp, sum, prod);
    modport sink   (input valid, op, raw_a, raw_b, sign, exp, sum, prod);
endinterface

// Stage 3 to stage 4, normalized significand and rounding decision
interface round_if;
    import fpu_pkg::*;

    logic     valid;
    alu_op_t  op;
    fp_word_t raw_a;
    fp_word_t raw_b;
    logic     sign;
    exp_t     exp;
    sig_t     sig;
    logic     round_up;

    modport source (output valid, op, raw_a, raw_b, sign, exp, sig, round_up);
    modport sink   (input valid, op, raw_a, raw_b, sign, exp, sig, round_up);
endinterface

/* common/fpu_pkg.sv */
package fpu_pkg;

    // ============================================================
    // IEEE single precision field widths
    // ============================================================
    localparam int FRAC_W   = 23;
    localparam int SIG_W    = 24;
    localparam int EXP_BIAS = 127;

    // Raw 32-bit word, operand or result
    typedef logic [31:0] fp_word_t;
    typedef logic [7:0] exp_t;

    // Significand with the hidden one
    typedef logic [SIG_W-1:0] sig_t;

    // Aligned sum, one carry bit above the hidden one
    typedef logic [SIG_W:0] sum_t;
    typedef logic [2*SIG_W-1:0] prod_t;

    // All-ones exponent, infinity
    localparam exp_t EXP_INF = 8'hFF;

    // Compare results
    localparam fp_word_t TRUE_WORD  = 32'd1;
    localparam fp_word_t FALSE_WORD = 32'd0;

    // ============================================================
    // Operation encoding
    // ============================================================
    typedef enum logic [2:0] {
        FADD = 3'd0,
        FSUB = 3'd1,
        FMUL = 3'd2,
        FNEG = 3'd3,
        FABS = 3'd4,
        FEQ  = 3'd5,
        FSLT = 3'd6
    } alu_op_t;

endpackage
